// ==== logic/dual_issue_pkg.sv ====
`default_nettype none

package dual_issue_pkg;

  typedef enum logic [3:0] {
    op_nop,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_lui,
    op_branch,
    op_jal,
    op_load,
    op_store,
    op_mul,
    op_div,
    op_csr
  } op_code;

  localparam int reg_bits = 5;
  localparam int seq_bits = 8;    // Wraps around
  localparam int queue_depth = 8;
  localparam int ptr_bits = $clog2(queue_depth);
  localparam int count_bits = $clog2(queue_depth + 1);

  // Opcode tables, one bit per op_code value
  localparam logic [15:0] basic_ops = 16'h00fe;    // add .. jal
  localparam logic [15:0] complex_ops = 16'h1f00;  // load .. csr
  localparam logic [15:0] wren_ops = 16'h1dbe;     // All but branch and store
  localparam logic [15:0] rden1_ops = 16'h1f5e;    // All but lui and jal
  localparam logic [15:0] rden2_ops = 16'h0e5e;    // Register-register forms, branch, store

endpackage

`default_nettype wire

// ==== logic/pair_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_decoder (
  input  wire                                clock,
  input  wire                                reset,
  input  wire                                flush,
  input  wire                                in_valid,
  output logic                               in_ready,
  input  wire dual_issue_pkg::op_code        in_op0,
  input  wire dual_issue_pkg::op_code        in_op1,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rd0,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs1_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs2_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rd1,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs1_1,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs2_1,
  output logic                               dec_valid,
  input  wire                                dec_ready,
  output logic                               dec_valid_0,
  output dual_issue_pkg::op_code             dec_op_0,
  output logic [dual_issue_pkg::reg_bits-1:0] dec_rd_0,
  output logic [dual_issue_pkg::reg_bits-1:0] dec_rs1_0,
  output logic [dual_issue_pkg::reg_bits-1:0] dec_rs2_0,
  output logic                               dec_complex_0,
  output logic                               dec_wren_0,
  output logic                               dec_rden1_0,
  output logic                               dec_rden2_0,
  output logic [dual_issue_pkg::seq_bits-1:0] dec_seq_0,
  output logic                               dec_valid_1,
  output dual_issue_pkg::op_code             dec_op_1,
  output logic [dual_issue_pkg::reg_bits-1:0] dec_rd_1,
  output logic [dual_issue_pkg::reg_bits-1:0] dec_rs1_1,
  output logic [dual_issue_pkg::reg_bits-1:0] dec_rs2_1,
  output logic                               dec_complex_1,
  output logic                               dec_wren_1,
  output logic                               dec_rden1_1,
  output logic                               dec_rden2_1,
  output logic [dual_issue_pkg::seq_bits-1:0] dec_seq_1
);

  logic running;
  logic keep_0;
  logic keep_1;
  logic load;
  logic [1:0] keep_count;
  dual_issue_pkg::op_code sel_op;
  logic [dual_issue_pkg::reg_bits-1:0] sel_rd;
  logic [dual_issue_pkg::reg_bits-1:0] sel_rs1;
  logic [dual_issue_pkg::reg_bits-1:0] sel_rs2;
  logic [dual_issue_pkg::seq_bits-1:0] seq_count;

  // A nop is in neither table and is dropped
  assign keep_0 = dual_issue_pkg::basic_ops[in_op0] || dual_issue_pkg::complex_ops[in_op0];
  assign keep_1 = dual_issue_pkg::basic_ops[in_op1] || dual_issue_pkg::complex_ops[in_op1];
  assign keep_count = {1'b0, keep_0} + {1'b0, keep_1};

  assign in_ready = running && !flush && (!dec_valid || dec_ready);
  assign load = in_valid && in_ready;

  // Lone survivor moves into lane 0
  assign sel_op = keep_0 ? in_op0 : in_op1;
  assign sel_rd = keep_0 ? in_rd0 : in_rd1;
  assign sel_rs1 = keep_0 ? in_rs1_0 : in_rs1_1;
  assign sel_rs2 = keep_0 ? in_rs2_0 : in_rs2_1;

  always_ff @(posedge clock) begin
    if (!reset) begin
      running <= 1'b0;
      dec_valid <= 1'b0;
      seq_count <= '0;
    end else begin
      running <= 1'b1;
      if (flush) begin
        dec_valid <= 1'b0;
      end else if (load) begin
        dec_valid <= keep_0 || keep_1;   // All-nop pair is never sent
        seq_count <= seq_count + dual_issue_pkg::seq_bits'(keep_count);
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      dec_valid_0 <= keep_0 || keep_1;
      dec_op_0 <= sel_op;
      dec_rd_0 <= sel_rd;
      dec_rs1_0 <= sel_rs1;
      dec_rs2_0 <= sel_rs2;
      dec_complex_0 <= dual_issue_pkg::complex_ops[sel_op];
      dec_wren_0 <= dual_issue_pkg::wren_ops[sel_op] && (sel_rd != '0);
      dec_rden1_0 <= dual_issue_pkg::rden1_ops[sel_op];
      dec_rden2_0 <= dual_issue_pkg::rden2_ops[sel_op];
      dec_seq_0 <= seq_count;
      dec_valid_1 <= keep_0 && keep_1;
      dec_op_1 <= in_op1;
      dec_rd_1 <= in_rd1;
      dec_rs1_1 <= in_rs1_1;
      dec_rs2_1 <= in_rs2_1;
      dec_complex_1 <= dual_issue_pkg::complex_ops[in_op1];
      dec_wren_1 <= dual_issue_pkg::wren_ops[in_op1] && (in_rd1 != '0);
      dec_rden1_1 <= dual_issue_pkg::rden1_ops[in_op1];
      dec_rden2_1 <= dual_issue_pkg::rden2_ops[in_op1];
      dec_seq_1 <= seq_count + dual_issue_pkg::seq_bits'(1);
    end
  end

  a_hold_under_stall: assert property (@(posedge clock) disable iff (!reset || flush)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec_seq_0) && $stable(dec_op_0)
      && $stable(dec_valid_1));

endmodule

`default_nettype wire

// ==== logic/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
  input  wire                                clock,
  input  wire                                reset,
  input  wire                                flush,
  input  wire                                dec_valid,
  output logic                               dec_ready,
  input  wire                                dec_valid_0,
  input  wire dual_issue_pkg::op_code        dec_op_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] dec_rd_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] dec_rs1_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] dec_rs2_0,
  input  wire                                dec_complex_0,
  input  wire                                dec_wren_0,
  input  wire                                dec_rden1_0,
  input  wire                                dec_rden2_0,
  input  wire [dual_issue_pkg::seq_bits-1:0] dec_seq_0,
  input  wire                                dec_valid_1,
  input  wire dual_issue_pkg::op_code        dec_op_1,
  input  wire [dual_issue_pkg::reg_bits-1:0] dec_rd_1,
  input  wire [dual_issue_pkg::reg_bits-1:0] dec_rs1_1,
  input  wire [dual_issue_pkg::reg_bits-1:0] dec_rs2_1,
  input  wire                                dec_complex_1,
  input  wire                                dec_wren_1,
  input  wire                                dec_rden1_1,
  input  wire                                dec_rden2_1,
  input  wire [dual_issue_pkg::seq_bits-1:0] dec_seq_1,
  output logic                               issue_valid,
  input  wire                                issue_ready,
  output logic                               issue_pair,
  output logic                               issue_swap,
  output dual_issue_pkg::op_code             issue_op_0,
  output logic [dual_issue_pkg::reg_bits-1:0] issue_rd_0,
  output logic [dual_issue_pkg::seq_bits-1:0] issue_seq_0,
  output logic                               issue_complex_0,
  output dual_issue_pkg::op_code             issue_op_1,
  output logic [dual_issue_pkg::reg_bits-1:0] issue_rd_1,
  output logic [dual_issue_pkg::seq_bits-1:0] issue_seq_1,
  output logic                               issue_complex_1
);

  dual_issue_pkg::op_code q_op [0:dual_issue_pkg::queue_depth-1];
  logic [dual_issue_pkg::reg_bits-1:0] q_rd [0:dual_issue_pkg::queue_depth-1];
  logic [dual_issue_pkg::reg_bits-1:0] q_rs1 [0:dual_issue_pkg::queue_depth-1];
  logic [dual_issue_pkg::reg_bits-1:0] q_rs2 [0:dual_issue_pkg::queue_depth-1];
  logic [dual_issue_pkg::seq_bits-1:0] q_seq [0:dual_issue_pkg::queue_depth-1];
  logic q_complex [0:dual_issue_pkg::queue_depth-1];
  logic q_wren [0:dual_issue_pkg::queue_depth-1];
  logic q_rden1 [0:dual_issue_pkg::queue_depth-1];
  logic q_rden2 [0:dual_issue_pkg::queue_depth-1];

  logic [dual_issue_pkg::ptr_bits-1:0] wr_idx;
  logic [dual_issue_pkg::ptr_bits-1:0] wr_idx_1;
  logic [dual_issue_pkg::ptr_bits-1:0] rd_idx;
  logic [dual_issue_pkg::ptr_bits-1:0] young_idx;
  logic [dual_issue_pkg::count_bits-1:0] count;
  logic wr_en;
  logic both_complex;
  logic dep_hit;
  logic [1:0] wr_num;
  logic [1:0] rd_num;

  assign dec_ready = (count <= dual_issue_pkg::queue_depth - 2);  // Room for a full pair
  assign wr_en = dec_valid && dec_ready && !flush;
  assign wr_num = wr_en ? {1'b0, dec_valid_0} + {1'b0, dec_valid_1} : 2'd0;
  assign wr_idx_1 = wr_idx + dual_issue_pkg::ptr_bits'(dec_valid_0);

  // Oldest entry at rd_idx, next oldest right behind it
  assign young_idx = rd_idx + dual_issue_pkg::ptr_bits'(1);
  assign both_complex = q_complex[rd_idx] && q_complex[young_idx];
  assign dep_hit = q_wren[rd_idx] &&
    ((q_rden1[young_idx] && (q_rs1[young_idx] == q_rd[rd_idx])) ||
     (q_rden2[young_idx] && (q_rs2[young_idx] == q_rd[rd_idx])));

  assign issue_valid = (count != '0);
  assign issue_pair = (count > 1) && !both_complex && !dep_hit;
  assign issue_swap = issue_pair && !q_complex[rd_idx] && q_complex[young_idx];
  assign rd_num = (issue_valid && issue_ready) ? (issue_pair ? 2'd2 : 2'd1) : 2'd0;

  assign issue_op_0 = issue_swap ? q_op[young_idx] : q_op[rd_idx];
  assign issue_rd_0 = issue_swap ? q_rd[young_idx] : q_rd[rd_idx];
  assign issue_seq_0 = issue_swap ? q_seq[young_idx] : q_seq[rd_idx];
  assign issue_complex_0 = issue_swap ? q_complex[young_idx] : q_complex[rd_idx];
  assign issue_op_1 = issue_swap ? q_op[rd_idx] : q_op[young_idx];
  assign issue_rd_1 = issue_swap ? q_rd[rd_idx] : q_rd[young_idx];
  assign issue_seq_1 = issue_swap ? q_seq[rd_idx] : q_seq[young_idx];
  assign issue_complex_1 = issue_swap ? q_complex[rd_idx] : q_complex[young_idx];

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count <= '0;
    end else begin
      wr_idx <= wr_idx + dual_issue_pkg::ptr_bits'(wr_num);
      rd_idx <= rd_idx + dual_issue_pkg::ptr_bits'(rd_num);
      count <= count + dual_issue_pkg::count_bits'(wr_num)
               - dual_issue_pkg::count_bits'(rd_num);
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en && dec_valid_0) begin
      q_op[wr_idx] <= dec_op_0;
      q_rd[wr_idx] <= dec_rd_0;
      q_rs1[wr_idx] <= dec_rs1_0;
      q_rs2[wr_idx] <= dec_rs2_0;
      q_seq[wr_idx] <= dec_seq_0;
      q_complex[wr_idx] <= dec_complex_0;
      q_wren[wr_idx] <= dec_wren_0;
      q_rden1[wr_idx] <= dec_rden1_0;
      q_rden2[wr_idx] <= dec_rden2_0;
    end
    if (wr_en && dec_valid_1) begin
      q_op[wr_idx_1] <= dec_op_1;
      q_rd[wr_idx_1] <= dec_rd_1;
      q_rs1[wr_idx_1] <= dec_rs1_1;
      q_rs2[wr_idx_1] <= dec_rs2_1;
      q_seq[wr_idx_1] <= dec_seq_1;
      q_complex[wr_idx_1] <= dec_complex_1;
      q_wren[wr_idx_1] <= dec_wren_1;
      q_rden1[wr_idx_1] <= dec_rden1_1;
      q_rden2[wr_idx_1] <= dec_rden2_1;
    end
  end

  a_count_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= dual_issue_pkg::queue_depth);

  a_lane1_basic: assert property (@(posedge clock) disable iff (!reset || flush)
    issue_valid && issue_pair |-> !issue_complex_1);

endmodule

`default_nettype wire

// ==== logic/program_order_retire.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_order_retire (
  input  wire                                clock,
  input  wire                                reset,
  input  wire                                flush,
  input  wire                                issue_valid,
  output logic                               issue_ready,
  input  wire                                issue_pair,
  input  wire                                issue_swap,
  input  wire dual_issue_pkg::op_code        issue_op_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] issue_rd_0,
  input  wire [dual_issue_pkg::seq_bits-1:0] issue_seq_0,
  input  wire                                issue_complex_0,
  input  wire dual_issue_pkg::op_code        issue_op_1,
  input  wire [dual_issue_pkg::reg_bits-1:0] issue_rd_1,
  input  wire [dual_issue_pkg::seq_bits-1:0] issue_seq_1,
  input  wire                                issue_complex_1,
  output logic                               retire_valid,
  input  wire                                retire_ready,
  output dual_issue_pkg::op_code             retire_op,
  output logic [dual_issue_pkg::reg_bits-1:0] retire_rd,
  output logic [dual_issue_pkg::seq_bits-1:0] retire_seq,
  output logic                               retire_dual
);

  logic have_old;
  logic have_young;
  logic accept;
  logic emit;
  logic dual;
  dual_issue_pkg::op_code old_op;
  dual_issue_pkg::op_code young_op;
  logic [dual_issue_pkg::reg_bits-1:0] old_rd;
  logic [dual_issue_pkg::reg_bits-1:0] young_rd;
  logic [dual_issue_pkg::seq_bits-1:0] old_seq;
  logic [dual_issue_pkg::seq_bits-1:0] young_seq;

  assign issue_ready = !have_old && !have_young;   // Only takes a group when empty
  assign accept = issue_valid && issue_ready && !flush;

  assign retire_valid = have_old || have_young;
  assign emit = retire_valid && retire_ready;
  assign retire_op = have_old ? old_op : young_op;
  assign retire_rd = have_old ? old_rd : young_rd;
  assign retire_seq = have_old ? old_seq : young_seq;
  assign retire_dual = dual;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      have_old <= 1'b0;
      have_young <= 1'b0;
    end else if (accept) begin
      have_old <= 1'b1;
      have_young <= issue_pair;
    end else if (emit) begin
      if (have_old) begin
        have_old <= 1'b0;    // Oldest goes first
      end else begin
        have_young <= 1'b0;
      end
    end
  end

  // Swap undone here, so the slots hold program order
  always_ff @(posedge clock) begin
    if (accept) begin
      dual <= issue_pair;
      old_op <= issue_swap ? issue_op_1 : issue_op_0;
      old_rd <= issue_swap ? issue_rd_1 : issue_rd_0;
      old_seq <= issue_swap ? issue_seq_1 : issue_seq_0;
      young_op <= issue_swap ? issue_op_0 : issue_op_1;
      young_rd <= issue_swap ? issue_rd_0 : issue_rd_1;
      young_seq <= issue_swap ? issue_seq_0 : issue_seq_1;
    end
  end

  a_pair_consecutive: assert property (@(posedge clock) disable iff (!reset || flush)
    accept && issue_pair |=> (young_seq - old_seq) == dual_issue_pkg::seq_bits'(1));

  // A swap only ever moves a complex instruction forward
  a_swap_complex_first: assert property (@(posedge clock) disable iff (!reset || flush)
    issue_valid && issue_swap |-> issue_complex_0 && !issue_complex_1);

endmodule

`default_nettype wire

// ==== logic/dual_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_issue_top (
  input  wire                                clock,
  input  wire                                reset,
  input  wire                                flush,
  input  wire                                in_valid,
  output logic                               in_ready,
  input  wire dual_issue_pkg::op_code        in_op0,
  input  wire dual_issue_pkg::op_code        in_op1,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rd0,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs1_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs2_0,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rd1,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs1_1,
  input  wire [dual_issue_pkg::reg_bits-1:0] in_rs2_1,
  output logic                               retire_valid,
  input  wire                                retire_ready,
  output dual_issue_pkg::op_code             retire_op,
  output logic [dual_issue_pkg::reg_bits-1:0] retire_rd,
  output logic [dual_issue_pkg::seq_bits-1:0] retire_seq,
  output logic                               retire_dual
);

  logic dec_valid;
  logic dec_ready;
  logic dec_valid_0;
  logic dec_valid_1;
  dual_issue_pkg::op_code dec_op_0;
  dual_issue_pkg::op_code dec_op_1;
  logic [dual_issue_pkg::reg_bits-1:0] dec_rd_0;
  logic [dual_issue_pkg::reg_bits-1:0] dec_rd_1;
  logic [dual_issue_pkg::reg_bits-1:0] dec_rs1_0;
  logic [dual_issue_pkg::reg_bits-1:0] dec_rs1_1;
  logic [dual_issue_pkg::reg_bits-1:0] dec_rs2_0;
  logic [dual_issue_pkg::reg_bits-1:0] dec_rs2_1;
  logic dec_complex_0;
  logic dec_complex_1;
  logic dec_wren_0;
  logic dec_wren_1;
  logic dec_rden1_0;
  logic dec_rden1_1;
  logic dec_rden2_0;
  logic dec_rden2_1;
  logic [dual_issue_pkg::seq_bits-1:0] dec_seq_0;
  logic [dual_issue_pkg::seq_bits-1:0] dec_seq_1;

  logic issue_valid;
  logic issue_ready;
  logic issue_pair;
  logic issue_swap;
  dual_issue_pkg::op_code issue_op_0;
  dual_issue_pkg::op_code issue_op_1;
  logic [dual_issue_pkg::reg_bits-1:0] issue_rd_0;
  logic [dual_issue_pkg::reg_bits-1:0] issue_rd_1;
  logic [dual_issue_pkg::seq_bits-1:0] issue_seq_0;
  logic [dual_issue_pkg::seq_bits-1:0] issue_seq_1;
  logic issue_complex_0;
  logic issue_complex_1;

  // Port names match across the blocks
  pair_decoder i_pair_decoder (.*);

  issue_queue i_issue_queue (.*);

  program_order_retire i_program_order_retire (.*);

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  localparam int half_period = 50;

  initial begin
    clock = 1'b0;
    forever begin
      #half_period clock = ~clock;
    end
  end

  initial begin
    reset = 1'b0;                 // Active low for 3 cycles
    repeat (3) @(posedge clock);
    #10;
    reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/dual_issue_tests.svh ====
function automatic dual_issue_pkg::op_code chain_op();
  return dual_issue_pkg::op_code'(1 + random_below(4));   // add, sub, and, or
endfunction

task automatic test_order;
  $display("Test 1: program order with nops mixed in");
  ready_mode = 0;
  repeat (30) begin
    send_random_pair(25, 32);
  end
  wait_drain("order stream to retire");
endtask

// Small register span makes dependencies common
task automatic test_pairing;
  int duals_before;
  $display("Test 2: pairing rules");
  duals_before = dual_count;
  repeat (40) begin
    send_random_pair(10, 6);
  end
  wait_drain("pairing stream to retire");
  if (dual_count == duals_before) begin
    other_errors++;
    $display("No pair was dual-issued in the pairing stream");
  end
endtask

task automatic test_dep_chain;
  logic [dual_issue_pkg::reg_bits-1:0] prev_rd;
  logic [dual_issue_pkg::reg_bits-1:0] rd0;
  logic [dual_issue_pkg::reg_bits-1:0] rd1;
  int duals_before;
  $display("Test 3: dependency chain");
  prev_rd = 5'd1;
  duals_before = dual_count;
  for (int i = 0; i < 20; i++) begin
    rd0 = 5'(1 + (2 * i) % 31);
    rd1 = 5'(1 + (2 * i + 1) % 31);
    send_pair(chain_op(), rd0, prev_rd, 5'd0, chain_op(), rd1, rd0, 5'd0);
    prev_rd = rd1;
  end
  wait_drain("dependency chain to retire");
  if (dual_count != duals_before) begin
    other_errors++;
    $display("Dependency chain retired %0d dual instructions", dual_count - duals_before);
  end
endtask

task automatic test_back_pressure;
  $display("Test 4: back-pressure from retire_ready");
  ready_mode = 1;
  stall_seen = 1'b0;
  repeat (40) begin
    send_random_pair(0, 32);
  end
  wait_drain("stream under back-pressure to retire");
  ready_mode = 0;
  if (!stall_seen) begin
    other_errors++;
    $display("in_ready never fell while the queue was filling");
  end
endtask

task automatic test_flush;
  $display("Test 5: flush mid-stream");
  ready_mode = 2;
  repeat (3) begin
    send_random_pair(0, 32);
  end
  ready_mode = 0;
  repeat (2) begin
    send_random_pair(0, 32);
  end
  flush = 1'b1;
  @(posedge clock);
  #drive_delay;
  flush = 1'b0;
  expected_q.delete();      // Old stream is gone
  repeat (10) begin
    send_random_pair(20, 32);
  end
  wait_drain("stream after flush to retire");
endtask

// ==== verification/dual_issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_issue_tb;

  localparam int drive_delay = 10;
  localparam int wait_limit = 2000;

  logic clock;
  logic reset;
  logic flush;
  logic in_valid;
  logic in_ready;
  dual_issue_pkg::op_code in_op0;
  dual_issue_pkg::op_code in_op1;
  logic [dual_issue_pkg::reg_bits-1:0] in_rd0;
  logic [dual_issue_pkg::reg_bits-1:0] in_rs1_0;
  logic [dual_issue_pkg::reg_bits-1:0] in_rs2_0;
  logic [dual_issue_pkg::reg_bits-1:0] in_rd1;
  logic [dual_issue_pkg::reg_bits-1:0] in_rs1_1;
  logic [dual_issue_pkg::reg_bits-1:0] in_rs2_1;
  logic retire_valid;
  logic retire_ready;
  dual_issue_pkg::op_code retire_op;
  logic [dual_issue_pkg::reg_bits-1:0] retire_rd;
  logic [dual_issue_pkg::seq_bits-1:0] retire_seq;
  logic retire_dual;

  int stim_seed = 32'h3ba5;
  int ready_seed = 32'h3ba5;
  int value_errors = 0;
  int other_errors = 0;
  int sent_count = 0;           // Tag of the next non-nop instruction
  int dual_count = 0;
  int ready_mode = 0;           // 0 ready, 1 random, 2 held low
  bit stall_seen = 1'b0;
  bit dual_phase = 1'b0;
  logic [26:0] older_word;
  logic [26:0] expected_q [$];  // {op, rd, rs1, rs2, seq} in program order

  clock_gen i_clock_gen (
    .clock(clock),
    .reset(reset)
  );

  dual_issue_top i_dual_issue_top (.*);

  function automatic bit is_complex(input logic [3:0] op);
    return op inside {dual_issue_pkg::op_load, dual_issue_pkg::op_store, dual_issue_pkg::op_mul,
                      dual_issue_pkg::op_div, dual_issue_pkg::op_csr};
  endfunction

  function automatic bit writes_rd(input logic [3:0] op, input logic [4:0] rd);
    return !(op inside {dual_issue_pkg::op_branch, dual_issue_pkg::op_store}) && (rd != 5'd0);
  endfunction

  function automatic bit reads_rs1(input logic [3:0] op);
    return !(op inside {dual_issue_pkg::op_lui, dual_issue_pkg::op_jal});
  endfunction

  function automatic bit reads_rs2(input logic [3:0] op);
    return op inside {dual_issue_pkg::op_add, dual_issue_pkg::op_sub, dual_issue_pkg::op_and,
                      dual_issue_pkg::op_or, dual_issue_pkg::op_branch, dual_issue_pkg::op_store,
                      dual_issue_pkg::op_mul, dual_issue_pkg::op_div};
  endfunction

  function automatic int random_below(input int limit);
    return $unsigned($random(stim_seed)) % limit;
  endfunction

  function automatic dual_issue_pkg::op_code random_op(input int nop_pct);
    if (random_below(100) < nop_pct) begin
      return dual_issue_pkg::op_nop;
    end
    return dual_issue_pkg::op_code'(1 + random_below(12));
  endfunction

  task automatic finish_run;
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    other_errors++;
    $display("Timed out at %0t while waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic record_lane(input dual_issue_pkg::op_code op, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
    if (op != dual_issue_pkg::op_nop) begin
      expected_q.push_back({op, rd, rs1, rs2, sent_count[7:0]});
      sent_count++;
    end
  endtask

  task automatic send_pair(
    input dual_issue_pkg::op_code op0,
    input logic [dual_issue_pkg::reg_bits-1:0] rd0, rs1_0, rs2_0,
    input dual_issue_pkg::op_code op1,
    input logic [dual_issue_pkg::reg_bits-1:0] rd1, rs1_1, rs2_1
  );
    int waited;
    waited = 0;
    in_valid = 1'b1;
    in_op0 = op0;
    in_rd0 = rd0;
    in_rs1_0 = rs1_0;
    in_rs2_0 = rs2_0;
    in_op1 = op1;
    in_rd1 = rd1;
    in_rs1_1 = rs1_1;
    in_rs2_1 = rs2_1;
    @(negedge clock);
    while (in_ready !== 1'b1) begin
      stall_seen = 1'b1;
      waited++;
      if (waited > wait_limit) begin
        stop_on_timeout("in_ready");
      end
      @(negedge clock);
    end
    @(posedge clock);                       // Transfer edge
    record_lane(op0, rd0, rs1_0, rs2_0);    // Lane 0 is the older one
    record_lane(op1, rd1, rs1_1, rs2_1);
    #drive_delay;
    in_valid = 1'b0;
  endtask

  task automatic send_random_pair(input int nop_pct, input int reg_span);
    dual_issue_pkg::op_code op0;
    dual_issue_pkg::op_code op1;
    logic [4:0] r [0:5];
    op0 = random_op(nop_pct);
    op1 = random_op(nop_pct);
    foreach (r[i]) begin
      r[i] = 5'(random_below(reg_span));
    end
    send_pair(op0, r[0], r[1], r[2], op1, r[3], r[4], r[5]);
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (expected_q.size() != 0 || retire_valid !== 1'b0) begin
      @(posedge clock);
      #drive_delay;
      waited++;
      if (waited > wait_limit) begin
        stop_on_timeout(what);
      end
    end
  endtask

  task automatic check_pair(input logic [26:0] older, input logic [26:0] younger);
    if (is_complex(older[26:23]) && is_complex(younger[26:23])) begin
      other_errors++;
      $display("Two complex instructions paired, seq %0d and %0d", older[7:0], younger[7:0]);
    end
    if (writes_rd(older[26:23], older[22:18]) &&
        ((reads_rs1(younger[26:23]) && younger[17:13] == older[22:18]) ||
         (reads_rs2(younger[26:23]) && younger[12:8] == older[22:18]))) begin
      other_errors++;
      $display("Seq %0d paired with seq %0d whose rd it reads", younger[7:0], older[7:0]);
    end
  endtask

  task automatic check_retirement;
    logic [26:0] expected;
    if (expected_q.size() == 0) begin
      other_errors++;
      $display("Seq %0d retired at %0t with nothing pending", retire_seq, $time);
      return;
    end
    expected = expected_q.pop_front();
    if (retire_op !== expected[26:23]) begin
      value_errors++;
      $display("** Error at %0t: retire_op = %0d, expected %0d", $time, retire_op, expected[26:23]);
    end
    if (retire_rd !== expected[22:18]) begin
      value_errors++;
      $display("** Error at %0t: retire_rd = %0d, expected %0d", $time, retire_rd, expected[22:18]);
    end
    if (retire_seq !== expected[7:0]) begin
      value_errors++;
      $display("** Error at %0t: retire_seq = %0d, expected %0d", $time, retire_seq, expected[7:0]);
    end
    if (retire_dual !== 1'b1) begin
      if (dual_phase) begin
        other_errors++;
        $display("Dual instruction retired without its partner before seq %0d", retire_seq);
      end
      dual_phase = 1'b0;
    end else if (!dual_phase) begin
      dual_count++;
      older_word = expected;
      dual_phase = 1'b1;
    end else begin
      dual_count++;
      check_pair(older_word, expected);
      dual_phase = 1'b0;
    end
  endtask

  `include "dual_issue_tests.svh"

  always @(posedge clock) begin
    #drive_delay;
    case (ready_mode)
      1: retire_ready = ($random(ready_seed) & 1) != 0;
      2: retire_ready = 1'b0;
      default: retire_ready = 1'b1;
    endcase
  end

  // Retirement monitor, the transfer follows on the next rising edge
  always @(negedge clock) begin
    if (reset !== 1'b1 || flush) begin
      dual_phase = 1'b0;
    end else if (retire_valid === 1'b1 && retire_ready === 1'b1) begin
      check_retirement();
    end
  end

  initial begin
    int waited;
    waited = 0;
    flush = 1'b0;
    in_valid = 1'b0;
    in_op0 = dual_issue_pkg::op_nop;
    in_op1 = dual_issue_pkg::op_nop;
    in_rd0 = '0;
    in_rs1_0 = '0;
    in_rs2_0 = '0;
    in_rd1 = '0;
    in_rs1_1 = '0;
    in_rs2_1 = '0;
    retire_ready = 1'b1;
    repeat (2) @(posedge clock);
    #drive_delay;
    if (in_ready !== 1'b0 || retire_valid !== 1'b0) begin
      other_errors++;
      $display("in_ready or retire_valid not low during reset");
    end
    while (reset !== 1'b1) begin
      @(posedge clock);
      waited++;
      if (waited > 10) begin
        stop_on_timeout("reset release");
      end
    end
    @(posedge clock);
    #drive_delay;
    test_order();
    test_pairing();
    test_dep_chain();
    test_back_pressure();
    test_flush();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== dual_issue.f ====
+incdir+verification
logic/dual_issue_pkg.sv
logic/pair_decoder.sv
logic/issue_queue.sv
logic/program_order_retire.sv
logic/dual_issue_top.sv
verification/clock_gen.sv
verification/dual_issue_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dual_issue_tb
FILELIST = dual_issue.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	fi
	@echo "Simulation run clean"

clean:
	rm -rf $(BUILD) $(LOG)
